//--- hdl/pong_pkg.sv
/*
  pong ball controller definitions
  screen geometry for a 1024x768 field, vector types for coordinates,
  intervals and speed level, and the enums for direction and play state
*/

package pong_pkg;

  // vector types
  typedef logic [11:0] coord_t;
  typedef logic [19:0] interval_t;
  typedef logic [3:0]  level_t;

  // ball direction, vertical part first in the name
  typedef enum logic [1:0] {
    up_right   = 2'b00,
    down_right = 2'b01,
    down_left  = 2'b10,
    up_left    = 2'b11
  } dir_t;

  typedef enum logic {
    idle    = 1'b0,
    playing = 1'b1
  } play_state_t;

  // playfield walls, inclusive
  localparam coord_t left_wall  = 12'd1;
  localparam coord_t right_wall = 12'd1022;
  localparam coord_t up_wall    = 12'd1;
  localparam coord_t down_wall  = 12'd766;

  localparam coord_t central_line  = 12'd511;
  localparam coord_t ball_diameter = 12'd16;

  // racket sits at a fixed column, y comes from the mouse
  localparam coord_t racket_xpos   = 12'd60;
  localparam coord_t racket_length = 12'd80;

  // speed-up schedule
  localparam int     bounces_per_level = 6;
  localparam level_t max_level         = 4'd9;

endpackage

//--- hdl/pong_ball_cmd.sv
/*
  ball command decoder
  turns rising edges of the left mouse button into start and stop of play,
  and latches the difficulty input at each start
*/

module pong_ball_cmd (
  input  logic pclk,
  input  logic rst,
  input  logic mouse_left,
  input  logic difficulty,
  output logic play_start,
  output logic playing,
  output logic hard
);

  import pong_pkg::*;

  play_state_t state;
  play_state_t state_nxt;
  logic        btn_q;
  logic        btn_prev;
  logic        btn_rise;

  // rising edge of the registered button against its previous copy
  assign btn_rise = btn_q & ~btn_prev;

  // each button edge toggles between idle and play
  always_comb begin
    state_nxt = state;
    if (btn_rise) begin
      if (state == idle) begin
        state_nxt = pong_pkg::playing;
      end else begin
        state_nxt = idle;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      btn_q      <= 1'b0;
      btn_prev   <= 1'b0;
      state      <= idle;
      play_start <= 1'b0;
      hard       <= 1'b0;
    end else begin
      btn_q      <= mouse_left;
      btn_prev   <= btn_q;
      state      <= state_nxt;
      play_start <= btn_rise && (state == idle);
      // difficulty only matters at the moment play begins
      if (btn_rise && (state == idle)) begin
        hard <= difficulty;
      end
    end
  end

  assign playing = (state == pong_pkg::playing);

endmodule

//--- hdl/pong_ball_pace.sv
/*
  ball pace generator
  counts clock cycles toward the current step interval and issues a step
  strobe, shortening the interval on wall bounces in nine speed levels
*/

module pong_ball_pace #(
  parameter pong_pkg::interval_t interval_start       = 20'd524288,
  parameter pong_pkg::interval_t interval_change_easy = 20'd128,
  parameter pong_pkg::interval_t interval_change_hard = 20'd32768
) (
  input  logic              pclk,
  input  logic              rst,
  input  logic              playing,
  input  logic              play_start,
  input  logic              hard,
  input  logic              wall_hit,
  output logic              step,
  output pong_pkg::level_t  speed_level
);

  import pong_pkg::*;

  localparam int bounce_w = $clog2(bounces_per_level);

  interval_t           count;
  interval_t           interval;
  interval_t           change;
  interval_t           change_first;
  logic [bounce_w-1:0] bounces;
  logic                level_up;
  logic                can_speed_up;

  assign change_first = hard ? interval_change_hard : interval_change_easy;

  // counter runs 0..interval, so one step per interval+1 cycles
  assign step = playing && (count == interval);

  assign level_up     = (bounces == bounce_w'(bounces_per_level - 1));
  assign can_speed_up = wall_hit && (speed_level < max_level);

  always_ff @(posedge pclk) begin
    if (rst || !playing) begin
      count <= '0;
    end else if (step) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      interval    <= interval_start;
      change      <= interval_change_easy;
      bounces     <= '0;
      speed_level <= '0;
    end else if (!playing || play_start) begin
      interval <= interval_start;
      change   <= change_first;
      bounces  <= '0;
      // level stays visible while idle and restarts with the next game
      if (play_start) begin
        speed_level <= '0;
      end
    end else if (can_speed_up) begin
      // never let the interval wrap below zero
      if (interval > change) begin
        interval <= interval - change;
      end
      if (level_up) begin
        change      <= change >> 1;
        bounces     <= '0;
        speed_level <= speed_level + 1'b1;
      end else begin
        bounces <= bounces + 1'b1;
      end
    end
  end

endmodule

//--- hdl/pong_ball_motion.sv
/*
  ball motion
  holds the ball position and direction, moves one pixel diagonally per
  step and reflects off the four walls and off the racket
*/

module pong_ball_motion (
  input  logic              pclk,
  input  logic              rst,
  input  logic              playing,
  input  logic              step,
  input  pong_pkg::coord_t  mouse_ypos,
  output pong_pkg::coord_t  xpos,
  output pong_pkg::coord_t  ypos,
  output logic              wall_hit
);

  import pong_pkg::*;

  dir_t   dir;
  dir_t   dir_nxt;
  coord_t xpos_step;
  coord_t ypos_step;
  coord_t racket_top;
  coord_t racket_bottom;
  logic   going_up;
  logic   going_left;
  logic   hit_top;
  logic   hit_bottom;
  logic   hit_left;
  logic   hit_right;
  logic   touch;
  logic   bounce_v;
  logic   bounce_h;
  logic   on_racket;
  logic   new_up;
  logic   new_left;

  function automatic dir_t make_dir(input logic up, input logic left);
    dir_t d;
    if (up) begin
      if (left) begin
        d = up_left;
      end else begin
        d = up_right;
      end
    end else begin
      if (left) begin
        d = down_left;
      end else begin
        d = down_right;
      end
    end
    return d;
  endfunction

  assign going_up   = (dir == up_right) || (dir == up_left);
  assign going_left = (dir == down_left) || (dir == up_left);

  // right and bottom edges account for the ball size
  assign hit_top    = (ypos <= up_wall);
  assign hit_bottom = (ypos >= down_wall - ball_diameter);
  assign hit_left   = (xpos <= left_wall);
  assign hit_right  = (xpos >= right_wall - ball_diameter);
  assign touch      = hit_top || hit_bottom || hit_left || hit_right;

  // a wall only reflects when the ball is heading into it
  assign bounce_v = (going_up && hit_top) || (!going_up && hit_bottom);
  assign bounce_h = (going_left && hit_left) || (!going_left && hit_right);

  // clamp so a racket near the top edge does not wrap around
  assign racket_top    = (mouse_ypos > ball_diameter) ? mouse_ypos - ball_diameter : '0;
  assign racket_bottom = mouse_ypos + racket_length;

  assign on_racket = (xpos == racket_xpos) && going_left &&
                     (ypos >= racket_top) && (ypos <= racket_bottom);

  assign xpos_step = going_left ? xpos - 12'd1 : xpos + 12'd1;
  assign ypos_step = going_up   ? ypos - 12'd1 : ypos + 12'd1;

  // top and bottom walls come before the side walls
  // and the racket only counts when no wall is touched
  always_comb begin
    new_up   = going_up;
    new_left = going_left;
    if (touch) begin
      if (bounce_v) begin
        new_up = ~going_up;
      end else if (bounce_h) begin
        new_left = ~going_left;
      end
    end else if (on_racket) begin
      new_left = 1'b0;
    end
    dir_nxt = make_dir(new_up, new_left);
  end

  assign wall_hit = step && touch;

  always_ff @(posedge pclk) begin
    if (rst) begin
      xpos <= '0;
      ypos <= '0;
      dir  <= up_left;
    end else if (!playing) begin
      // ball parked on the centre line and riding along with the racket
      xpos <= central_line;
      ypos <= mouse_ypos;
      dir  <= up_left;
    end else if (step) begin
      xpos <= xpos_step;
      ypos <= ypos_step;
      dir  <= dir_nxt;
    end
  end

endmodule

//--- hdl/pong_ball_ctl.sv
/*
  pong ball controller top
  joins the button decoder, the pace generator and the motion block;
  ball position and speed level come straight from their registers
*/

module pong_ball_ctl #(
  parameter pong_pkg::interval_t interval_start       = 20'd524288,
  parameter pong_pkg::interval_t interval_change_easy = 20'd128,
  parameter pong_pkg::interval_t interval_change_hard = 20'd32768
) (
  input  logic              pclk,
  input  logic              rst,
  input  pong_pkg::coord_t  mouse_ypos,
  input  logic              mouse_left,
  input  logic              difficulty,
  output pong_pkg::coord_t  xpos,
  output pong_pkg::coord_t  ypos,
  output pong_pkg::level_t  speed_level
);

  logic play_start;
  logic playing;
  logic hard;
  logic step;
  logic wall_hit;

  pong_ball_cmd u_cmd (
    .pclk       (pclk),
    .rst        (rst),
    .mouse_left (mouse_left),
    .difficulty (difficulty),
    .play_start (play_start),
    .playing    (playing),
    .hard       (hard)
  );

  pong_ball_pace #(
    .interval_start       (interval_start),
    .interval_change_easy (interval_change_easy),
    .interval_change_hard (interval_change_hard)
  ) u_pace (
    .pclk        (pclk),
    .rst         (rst),
    .playing     (playing),
    .play_start  (play_start),
    .hard        (hard),
    .wall_hit    (wall_hit),
    .step        (step),
    .speed_level (speed_level)
  );

  // wall hits feed back into the pace schedule
  pong_ball_motion u_motion (
    .pclk       (pclk),
    .rst        (rst),
    .playing    (playing),
    .step       (step),
    .mouse_ypos (mouse_ypos),
    .xpos       (xpos),
    .ypos       (ypos),
    .wall_hit   (wall_hit)
  );

endmodule

//--- dv/tb_clock.sv
/*
  testbench clock source
  free-running clock that starts low, period set by parameter
*/

module tb_clock #(
  parameter int period = 100
) (
  output logic pclk
);

  initial begin
    pclk = 1'b0;
  end

  always begin
    #(period / 2);
    pclk = ~pclk;
  end

endmodule

//--- dv/pong_ball_ctl_tb.sv
/*
  testbench for the pong ball controller
  reads test steps from a data file, drives button, difficulty and mouse
  on the falling clock edge and compares ball position and speed level
*/

module pong_ball_ctl_tb;

  import pong_pkg::*;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;
  localparam int idle_samples = 8;
  localparam int spare_cycles = 1000;

  logic   pclk;
  logic   rst;
  coord_t mouse_ypos;
  logic   mouse_left;
  logic   difficulty;
  coord_t xpos;
  coord_t ypos;
  level_t speed_level;

  // one entry per test step of the data file
  string name_q[$];
  int    left_q[$];
  int    diff_q[$];
  int    ypos_in_q[$];
  int    cycles_q[$];
  int    exp_x_q[$];
  int    exp_y_q[$];
  int    exp_level_q[$];

  int     coord_errors;
  int     level_errors;
  int     other_errors;
  integer seed;
  longint total_cycles;
  logic   vectors_loaded;

  tb_clock #(
    .period (clk_period)
  ) clock_inst (
    .pclk (pclk)
  );

  // short intervals so a screen crossing stays within tens of thousands of cycles
  pong_ball_ctl #(
    .interval_start       (20'd40),
    .interval_change_easy (20'd4),
    .interval_change_hard (20'd16)
  ) pong_ball_ctl_inst (
    .pclk        (pclk),
    .rst         (rst),
    .mouse_ypos  (mouse_ypos),
    .mouse_left  (mouse_left),
    .difficulty  (difficulty),
    .xpos        (xpos),
    .ypos        (ypos),
    .speed_level (speed_level)
  );

  task automatic check_coord(input string name, input string what,
                             input coord_t expected, input coord_t actual);
    if (actual !== expected) begin
      coord_errors++;
      $display("error %s %s expected %0d actual %0d at %0t",
               name, what, expected, actual, $time);
    end
  endtask

  task automatic check_level(input string name, input level_t expected,
                             input level_t actual);
    if (actual !== expected) begin
      level_errors++;
      $display("error %s speed_level expected %0d actual %0d at %0t",
               name, expected, actual, $time);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    fields;
    int    vals[7];
    string line;
    string name;
    fd = $fopen("dv/pong_ball_input.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the stimulus file dv/pong_ball_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // blank lines and comment lines carry no test step
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          fields = $sscanf(line, "%s %d %d %d %d %d %d %d", name, vals[0], vals[1],
                           vals[2], vals[3], vals[4], vals[5], vals[6]);
          if (fields == 8) begin
            name_q.push_back(name);
            left_q.push_back(vals[0]);
            diff_q.push_back(vals[1]);
            ypos_in_q.push_back(vals[2]);
            cycles_q.push_back(vals[3]);
            exp_x_q.push_back(vals[4]);
            exp_y_q.push_back(vals[5]);
            exp_level_q.push_back(vals[6]);
            total_cycles += vals[3];
          end else begin
            other_errors++;
            $display("stimulus line could not be read: %s", line);
          end
        end
      end
      $fclose(fd);
      if (name_q.size() == 0) begin
        other_errors++;
        $display("stimulus file holds no test steps");
      end
    end
    vectors_loaded = 1'b1;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (reset_cycles) @(posedge pclk);
    @(negedge pclk);
    rst = 1'b0;
    check_coord("reset", "xpos", 12'd0, xpos);
    check_coord("reset", "ypos", 12'd0, ypos);
    check_level("reset", 4'd0, speed_level);
  endtask

  // parked ball follows the mouse one cycle later
  task automatic follow_random_idle();
    coord_t y_rand;
    for (int i = 0; i < idle_samples; i++) begin
      y_rand = coord_t'($unsigned($random(seed)) % 700);
      mouse_ypos = y_rand;
      @(negedge pclk);
      check_coord("random_idle", "xpos", central_line, xpos);
      check_coord("random_idle", "ypos", y_rand, ypos);
      check_level("random_idle", 4'd0, speed_level);
    end
  endtask

  task automatic run_vector(input int idx);
    mouse_left = (left_q[idx] != 0);
    difficulty = (diff_q[idx] != 0);
    mouse_ypos = coord_t'(ypos_in_q[idx]);
    repeat (cycles_q[idx]) @(posedge pclk);
    @(negedge pclk);
    check_coord(name_q[idx], "xpos", coord_t'(exp_x_q[idx]), xpos);
    check_coord(name_q[idx], "ypos", coord_t'(exp_y_q[idx]), ypos);
    check_level(name_q[idx], level_t'(exp_level_q[idx]), speed_level);
  endtask

  initial begin
    seed           = 32'h41f6;
    rst            = 1'b1;
    mouse_left     = 1'b0;
    difficulty     = 1'b0;
    mouse_ypos     = '0;
    coord_errors   = 0;
    level_errors   = 0;
    other_errors   = 0;
    total_cycles   = 0;
    vectors_loaded = 1'b0;
    load_vectors();
    apply_reset();
    follow_random_idle();
    foreach (name_q[i]) begin
      run_vector(i);
    end
    $display("errors: coordinate %0d, speed level %0d, other %0d",
             coord_errors, level_errors, other_errors);
    if (coord_errors + level_errors + other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // limit from the data file length plus margin for reset and idle checks
  initial begin
    wait (vectors_loaded === 1'b1);
    #((total_cycles + spare_cycles) * clk_period);
    other_errors++;
    $display("simulation timed out after %0d cycles", total_cycles + spare_cycles);
    $display("errors: coordinate %0d, speed level %0d, other %0d",
             coord_errors, level_errors, other_errors);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- pong_ball_ctl.f
hdl/pong_pkg.sv
hdl/pong_ball_cmd.sv
hdl/pong_ball_pace.sv
hdl/pong_ball_motion.sv
hdl/pong_ball_ctl.sv
dv/tb_clock.sv
dv/pong_ball_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the pong ball controller testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module pong_ball_ctl_tb \
  -f pong_ball_ctl.f -o pong_ball_ctl_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/pong_ball_ctl_sim > sim.log 2>&1 \
  && cat sim.log \
  || { cat sim.log; echo "simulator returned an error"; exit 1; }

test -s sim.log || { echo "simulation log is empty"; exit 1; }
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

//--- dv/pong_ball_input.txt
# name mouse_left difficulty mouse_ypos cycles exp_xpos exp_ypos exp_speed_level
# decimal values, cycles are rising clock edges after the inputs change
idle_a 0 0 100 2 511 100 0
idle_b 0 0 41 1 511 41 0
click_easy 1 0 41 2 511 41 0
hold_first 0 0 380 40 511 41 0
first_step 0 0 380 1 510 40 0
second_step 0 0 380 41 509 39 0
near_top 0 0 380 1558 471 1 0
top_hit 0 0 380 41 470 0 0
top_rebound 0 0 380 37 469 1 0
top_leave 0 0 380 33 468 2 0
down_left 0 0 380 29 467 3 0
no_early_step 0 0 380 28 467 3 0
shorter_step 0 0 380 1 466 4 0
at_racket 0 0 380 11774 60 410 0
racket_turn 0 0 380 29 59 411 0
moving_right 0 0 380 29 60 412 0
near_bottom 0 0 380 9802 398 750 0
bottom_hit 0 0 380 29 399 751 0
bottom_rebound 0 0 380 25 400 750 0
level_one 0 0 380 21 401 749 1
level_one_step 0 0 380 17 402 748 1
stop_click 1 0 300 3 511 300 1
stop_release 0 0 300 4 511 300 1
idle_follow 0 0 250 1 511 250 1
click_hard 1 1 600 3 511 600 0
hard_first 0 0 600 40 510 599 0
near_left 0 0 600 20869 1 90 0
left_hit 0 0 600 41 0 89 0
left_rebound 0 0 600 25 1 88 0
left_leave 0 0 600 9 2 87 0
up_right 0 0 600 9 3 86 0
near_top_hard 0 0 600 765 88 1 0
top_hit_hard 0 0 600 9 89 0 0
level_one_hard 0 0 600 18 91 2 1
level_one_next 0 0 600 9 92 3 1
final_click 1 0 200 3 511 200 1
final_idle 0 0 123 2 511 123 1
